// ==== logic/line_pkg.sv ====
// Line coding constants and transmitter states, referenced by scoped name from tx and rx logic
package line_pkg;

	// ------------------------------
	// Preamble shape
	// ------------------------------

	// Whole preamble length in clock cycles
	localparam int PREAMBLE_CYCLES = 100;

	// Level held between toggles, first level is high
	localparam int PREAMBLE_HALF = 10;

	// ------------------------------
	// Transmitter FSM
	// ------------------------------

	// Idle       line low, waiting for a start pulse
	// Preamble   alternating levels
	// Start      low for one bit time, then high for one bit time
	// Data       eight Manchester cells, MSB first
	// Stop       high half, low half
	// Done       one cycle of cleanup before idle
	typedef enum logic [3:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_DONE
	} tx_state_e;

endpackage

// ==== logic/frame_pkg.sv ====
// Frame payload types shared by the transmit buffer, the receiver and the link top level
package frame_pkg;

	// ------------------------------
	// Payload widths
	// ------------------------------

	// One byte on the line
	typedef logic [7:0] byte_t;

	// Bytes in a frame, also a buffer index
	typedef logic [7:0] count_t;

	// ------------------------------
	// Receive handshake payload
	// ------------------------------

	// Offered byte plus lost-byte marker
	// Overrun set when at least one byte was dropped
	// since the previous offer
	typedef struct packed {
		logic  overrun;
		byte_t data;
	} rx_byte_t;

endpackage

// ==== logic/tx_frame_buffer.sv ====
// Transmit frame buffer, collects host bytes by handshake and feeds them to the Manchester transmitter
`timescale 1ns/1ps

module tx_frame_buffer #(
	parameter int BUF_DEPTH = 16
) (
	input  logic              i_clk_100m,
	input  logic              i_rst_n,
	input  logic              i_wr_req,
	input  frame_pkg::byte_t  i_wr_byte,
	output logic              o_wr_ack,
	input  logic              i_send_req,
	output logic              o_send_ack,
	output logic              o_tx_start,
	output frame_pkg::count_t o_tx_count,
	output frame_pkg::byte_t  o_tx_byte,
	input  logic              i_tx_byte_done,
	input  logic              i_tx_frame_done
);

	localparam int IDX_W = $clog2(BUF_DEPTH);
	localparam frame_pkg::count_t DEPTH_CNT = frame_pkg::count_t'(BUF_DEPTH);

	typedef enum logic [1:0] {
		BUF_IDLE,
		BUF_WR_ACK,
		BUF_SEND,
		BUF_SEND_ACK
	} buf_state_e;

	buf_state_e        state;
	frame_pkg::byte_t  mem [BUF_DEPTH];
	frame_pkg::count_t wr_idx;
	frame_pkg::count_t rd_idx;
	logic              buf_full;
	logic              wr_take;

	assign buf_full = (wr_idx == DEPTH_CNT);
	// Writes only between frames, never when full
	assign wr_take = (state == BUF_IDLE) && i_wr_req && !buf_full;

	// Frame length is the fill level, frozen while sending
	assign o_tx_count = wr_idx;
	assign o_tx_byte = mem[rd_idx[IDX_W-1:0]];

	// Byte storage
	always_ff @(posedge i_clk_100m) begin
		if (wr_take)
			mem[wr_idx[IDX_W-1:0]] <= i_wr_byte;
	end

	// ------------------------------
	// Handshake FSM
	// ------------------------------
	always_ff @(posedge i_clk_100m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= BUF_IDLE;
			wr_idx     <= '0;
			rd_idx     <= '0;
			o_wr_ack   <= 1'b0;
			o_send_ack <= 1'b0;
			o_tx_start <= 1'b0;
		end else begin
			o_tx_start <= 1'b0;
			case (state)
				BUF_IDLE: begin
					if (wr_take) begin
						wr_idx   <= wr_idx + 8'd1;
						o_wr_ack <= 1'b1;
						state    <= BUF_WR_ACK;
					end else if (i_send_req && (wr_idx != '0)) begin
						// Request level seen here is always a fresh one
						rd_idx     <= '0;
						o_tx_start <= 1'b1;
						state      <= BUF_SEND;
					end
				end
				BUF_WR_ACK: begin
					if (!i_wr_req) begin
						o_wr_ack <= 1'b0;
						state    <= BUF_IDLE;
					end
				end
				BUF_SEND: begin
					// Next entry once the current stop cell ends
					if (i_tx_byte_done)
						rd_idx <= rd_idx + 8'd1;
					if (i_tx_frame_done) begin
						o_send_ack <= 1'b1;
						state      <= BUF_SEND_ACK;
					end
				end
				BUF_SEND_ACK: begin
					// Frame consumed, buffer empties
					if (!i_send_req) begin
						o_send_ack <= 1'b0;
						wr_idx     <= '0;
						rd_idx     <= '0;
						state      <= BUF_IDLE;
					end
				end
				default: state <= BUF_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/manch_tx.sv ====
// Manchester transmitter, drives preamble, start, data and stop cells for each buffered byte
`timescale 1ns/1ps

module manch_tx #(
	parameter int BIT_CYCLES = 10
) (
	input  logic              i_clk_100m,
	input  logic              i_rst_n,
	input  logic              i_tx_start,
	input  frame_pkg::count_t i_tx_count,
	input  frame_pkg::byte_t  i_tx_byte,
	output logic              o_tx_byte_done,
	output logic              o_tx_frame_done,
	output logic              o_tx_line
);

	// Cycle counter limits
	localparam logic [15:0] HALF_LAST = 16'(line_pkg::PREAMBLE_HALF - 1);
	localparam logic [3:0] HALVES_LAST =
		4'(line_pkg::PREAMBLE_CYCLES / line_pkg::PREAMBLE_HALF - 1);
	localparam logic [15:0] START_LAST = 16'(2 * BIT_CYCLES - 1);
	localparam logic [15:0] START_MID = 16'(BIT_CYCLES);
	localparam logic [15:0] CELL_LAST = 16'(BIT_CYCLES - 1);
	localparam logic [15:0] CELL_MID = 16'(BIT_CYCLES / 2);

	line_pkg::tx_state_e state;
	line_pkg::tx_state_e state_d;
	logic [15:0]         cyc_cnt;
	logic [15:0]         cyc_cnt_d;
	// Preamble half index, or data bit index
	logic [3:0]          bit_cnt;
	logic [3:0]          bit_cnt_d;
	frame_pkg::count_t   byte_cnt;
	frame_pkg::count_t   byte_cnt_d;
	logic                line_d;
	logic                cell_end;
	logic                last_byte;

	assign cell_end = (state == line_pkg::TX_STOP) && (cyc_cnt == CELL_LAST);
	assign last_byte = (byte_cnt == (i_tx_count - 8'd1));

	// Pulses in the last stop cycle
	assign o_tx_byte_done = cell_end;
	assign o_tx_frame_done = cell_end && last_byte;

	// ------------------------------
	// Next state and counters
	// ------------------------------
	always_comb begin
		state_d    = state;
		cyc_cnt_d  = cyc_cnt + 16'd1;
		bit_cnt_d  = bit_cnt;
		byte_cnt_d = byte_cnt;
		case (state)
			line_pkg::TX_IDLE: begin
				cyc_cnt_d  = '0;
				bit_cnt_d  = '0;
				byte_cnt_d = '0;
				if (i_tx_start)
					state_d = line_pkg::TX_PREAMBLE;
			end
			line_pkg::TX_PREAMBLE: begin
				if (cyc_cnt == HALF_LAST) begin
					cyc_cnt_d = '0;
					bit_cnt_d = bit_cnt + 4'd1;
					if (bit_cnt == HALVES_LAST) begin
						bit_cnt_d = '0;
						state_d   = line_pkg::TX_START;
					end
				end
			end
			line_pkg::TX_START: begin
				if (cyc_cnt == START_LAST) begin
					cyc_cnt_d = '0;
					state_d   = line_pkg::TX_DATA;
				end
			end
			line_pkg::TX_DATA: begin
				if (cyc_cnt == CELL_LAST) begin
					cyc_cnt_d = '0;
					bit_cnt_d = bit_cnt + 4'd1;
					if (bit_cnt == 4'd7) begin
						bit_cnt_d = '0;
						state_d   = line_pkg::TX_STOP;
					end
				end
			end
			line_pkg::TX_STOP: begin
				if (cell_end) begin
					cyc_cnt_d  = '0;
					byte_cnt_d = byte_cnt + 8'd1;
					// Loop back to a start cell until the count is reached
					state_d = last_byte ? line_pkg::TX_DONE : line_pkg::TX_START;
				end
			end
			line_pkg::TX_DONE: state_d = line_pkg::TX_IDLE;
			default: state_d = line_pkg::TX_IDLE;
		endcase
	end

	// Line level for the coming cycle
	always_comb begin
		case (state_d)
			line_pkg::TX_PREAMBLE: line_d = ~bit_cnt_d[0];
			line_pkg::TX_START:    line_d = (cyc_cnt_d >= START_MID);
			// Bit first, inverse after midpoint
			line_pkg::TX_DATA:
				line_d = i_tx_byte[3'd7 - bit_cnt_d[2:0]] ^ (cyc_cnt_d >= CELL_MID);
			line_pkg::TX_STOP:     line_d = (cyc_cnt_d < CELL_MID);
			default:               line_d = 1'b0;
		endcase
	end

	// ------------------------------
	// State and line registers
	// ------------------------------
	always_ff @(posedge i_clk_100m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= line_pkg::TX_IDLE;
			cyc_cnt   <= '0;
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			o_tx_line <= 1'b0;
		end else begin
			state     <= state_d;
			cyc_cnt   <= cyc_cnt_d;
			bit_cnt   <= bit_cnt_d;
			byte_cnt  <= byte_cnt_d;
			o_tx_line <= line_d;
		end
	end

endmodule

// ==== logic/manch_rx.sv ====
// Manchester receiver, finds start cells, decodes bytes and offers them on a four-phase handshake
`timescale 1ns/1ps

module manch_rx #(
	parameter int BIT_CYCLES = 10
) (
	input  logic                i_clk_100m,
	input  logic                i_rst_n,
	input  logic                i_rx_line,
	output logic                o_rx_req,
	output frame_pkg::rx_byte_t o_rx_byte,
	input  logic                i_rx_ack
);

	// Low run longer than any data or preamble low, at least one bit time
	localparam int LOW_RUN = (BIT_CYCLES > line_pkg::PREAMBLE_HALF) ?
		BIT_CYCLES : line_pkg::PREAMBLE_HALF;
	localparam logic [15:0] LOW_MIN = 16'(LOW_RUN + 1);
	localparam logic [15:0] CELL_LAST = 16'(BIT_CYCLES - 1);
	// Sample points, quarter and three quarters into a cell
	localparam logic [15:0] QTR = 16'(BIT_CYCLES / 4);
	localparam logic [15:0] QTR3 = 16'(BIT_CYCLES / 2 + BIT_CYCLES / 4);

	typedef enum logic [1:0] {
		RX_HUNT,
		RX_SKIP,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e        state;
	logic [1:0]       line_sync;
	logic [15:0]      low_cnt;
	logic [15:0]      cyc_cnt;
	logic [2:0]       bit_cnt;
	logic             first_half;
	logic             stop_ok;
	logic             overrun;
	frame_pkg::byte_t shift_reg;
	logic             line_s;
	logic             byte_ok;
	logic             offer;

	assign line_s = line_sync[1];
	// Complete byte with a good stop half
	assign byte_ok = (state == RX_STOP) && (cyc_cnt == CELL_LAST) && stop_ok;
	// Holding register free only when both handshake lines are low
	assign offer = byte_ok && !o_rx_req && !i_rx_ack;

	// ------------------------------
	// Line sync and low run length
	// ------------------------------
	always_ff @(posedge i_clk_100m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			line_sync <= '0;
			low_cnt   <= '0;
		end else begin
			line_sync <= {line_sync[0], i_rx_line};
			if (line_s)
				low_cnt <= '0;
			else if (low_cnt != 16'hffff)
				low_cnt <= low_cnt + 16'd1;
		end
	end

	// Shifter and offered byte
	always_ff @(posedge i_clk_100m) begin
		if ((state == RX_DATA) && (cyc_cnt == QTR3))
			shift_reg <= {shift_reg[6:0], first_half};
		if (offer) begin
			o_rx_byte.data    <= shift_reg;
			o_rx_byte.overrun <= overrun;
		end
	end

	// ------------------------------
	// Decoder FSM and handshake
	// ------------------------------
	always_ff @(posedge i_clk_100m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= RX_HUNT;
			cyc_cnt    <= '0;
			bit_cnt    <= '0;
			first_half <= 1'b0;
			stop_ok    <= 1'b0;
			overrun    <= 1'b0;
			o_rx_req   <= 1'b0;
		end else begin
			cyc_cnt <= cyc_cnt + 16'd1;
			if (o_rx_req && i_rx_ack)
				o_rx_req <= 1'b0;
			// Busy holding register, drop byte and mark the next one
			if (offer) begin
				o_rx_req <= 1'b1;
				overrun  <= 1'b0;
			end else if (byte_ok) begin
				overrun <= 1'b1;
			end
			case (state)
				RX_HUNT: begin
					// Rise in the middle of a start cell
					if (line_s && (low_cnt >= LOW_MIN)) begin
						cyc_cnt <= 16'd1;
						state   <= RX_SKIP;
					end
				end
				RX_SKIP: begin
					if (cyc_cnt == CELL_LAST) begin
						cyc_cnt <= '0;
						bit_cnt <= '0;
						state   <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (cyc_cnt == QTR)
						first_half <= line_s;
					// No transition mid-cell, not a real frame
					if ((cyc_cnt == QTR3) && (line_s == first_half))
						state <= RX_HUNT;
					if (cyc_cnt == CELL_LAST) begin
						cyc_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (cyc_cnt == QTR)
						stop_ok <= line_s;
					if (cyc_cnt == CELL_LAST)
						state <= RX_HUNT;
				end
				default: state <= RX_HUNT;
			endcase
		end
	end

endmodule

// ==== logic/manch_link_top.sv ====
// Manchester link top level, wires the frame buffer, transmitter and receiver and sets timing
`timescale 1ns/1ps

module manch_link_top #(
	parameter int BIT_CYCLES = 10,
	parameter int BUF_DEPTH = 16
) (
	input  logic                i_clk_100m,
	input  logic                i_rst_n,
	input  logic                i_wr_req,
	input  frame_pkg::byte_t    i_wr_byte,
	output logic                o_wr_ack,
	input  logic                i_send_req,
	output logic                o_send_ack,
	output logic                o_tx_line,
	input  logic                i_rx_line,
	output logic                o_rx_req,
	output frame_pkg::rx_byte_t o_rx_byte,
	input  logic                i_rx_ack
);

	// Buffer to transmitter
	logic              tx_start;
	logic              tx_byte_done;
	logic              tx_frame_done;
	frame_pkg::count_t tx_count;
	frame_pkg::byte_t  tx_byte;

	tx_frame_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) i_tx_frame_buffer (
		.i_clk_100m     (i_clk_100m),
		.i_rst_n        (i_rst_n),
		.i_wr_req       (i_wr_req),
		.i_wr_byte      (i_wr_byte),
		.o_wr_ack       (o_wr_ack),
		.i_send_req     (i_send_req),
		.o_send_ack     (o_send_ack),
		.o_tx_start     (tx_start),
		.o_tx_count     (tx_count),
		.o_tx_byte      (tx_byte),
		.i_tx_byte_done (tx_byte_done),
		.i_tx_frame_done(tx_frame_done)
	);

	manch_tx #(
		.BIT_CYCLES(BIT_CYCLES)
	) i_manch_tx (
		.i_clk_100m     (i_clk_100m),
		.i_rst_n        (i_rst_n),
		.i_tx_start     (tx_start),
		.i_tx_count     (tx_count),
		.i_tx_byte      (tx_byte),
		.o_tx_byte_done (tx_byte_done),
		.o_tx_frame_done(tx_frame_done),
		.o_tx_line      (o_tx_line)
	);

	// Receive path, independent of the send path
	manch_rx #(
		.BIT_CYCLES(BIT_CYCLES)
	) i_manch_rx (
		.i_clk_100m(i_clk_100m),
		.i_rst_n   (i_rst_n),
		.i_rx_line (i_rx_line),
		.o_rx_req  (o_rx_req),
		.o_rx_byte (o_rx_byte),
		.i_rx_ack  (i_rx_ack)
	);

endmodule

// ==== testbench/manch_tx_properties.sv ====
// Line timing checks for the Manchester transmitter, attached to every manch_tx instance by bind
`timescale 1ns/1ps

module manch_tx_properties #(
	parameter int BIT_CYCLES = 10
) (
	input logic                i_clk_100m,
	input logic                i_rst_n,
	input logic                i_tx_start,
	input frame_pkg::count_t   i_tx_count,
	input line_pkg::tx_state_e i_state,
	input logic [15:0]         i_cyc_cnt,
	input logic                i_line,
	input logic                i_frame_done
);

	localparam logic [15:0] CELL_MID = 16'(BIT_CYCLES / 2);

	logic prev_line;
	// Cycles since the last line change
	int   run_len;
	// Cycles since the frame start pulse
	int   frame_cyc;
	// Sticky failure markers, one per assertion
	logic preamble_bad = 1'b0;
	logic mid_bad = 1'b0;
	logic len_bad = 1'b0;
	logic timing_bad;

	assign timing_bad = preamble_bad | mid_bad | len_bad;

	always_ff @(posedge i_clk_100m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prev_line <= 1'b0;
			run_len   <= 0;
			frame_cyc <= 0;
		end else begin
			prev_line <= i_line;
			run_len   <= (i_line != prev_line) ? 1 : run_len + 1;
			frame_cyc <= (i_tx_start && (i_state == line_pkg::TX_IDLE)) ? 1 : frame_cyc + 1;
		end
	end

	// ------------------------------
	// Line timing
	// ------------------------------

	// Preamble toggles only after a full half
	preamble_half: assert property (@(posedge i_clk_100m) disable iff (!i_rst_n)
		(i_state == line_pkg::TX_PREAMBLE) && ($past(i_state) == line_pkg::TX_PREAMBLE) &&
		(i_line != prev_line) |-> (run_len == line_pkg::PREAMBLE_HALF))
	else begin
		preamble_bad = 1'b1;
		$error("preamble half does not last the expected number of cycles");
	end

	// Every data cell flips at its midpoint
	data_mid: assert property (@(posedge i_clk_100m) disable iff (!i_rst_n)
		(i_state == line_pkg::TX_DATA) && (i_cyc_cnt == CELL_MID) |-> (i_line != prev_line))
	else begin
		mid_bad = 1'b1;
		$error("data cell has no transition at its midpoint");
	end

	// Preamble plus eleven cells per byte
	frame_len: assert property (@(posedge i_clk_100m) disable iff (!i_rst_n)
		i_frame_done |->
		(frame_cyc == line_pkg::PREAMBLE_CYCLES + 11 * BIT_CYCLES * int'(i_tx_count)))
	else begin
		len_bad = 1'b1;
		$error("frame length differs from preamble plus eleven cells per byte");
	end

endmodule

bind manch_tx manch_tx_properties #(
	.BIT_CYCLES(BIT_CYCLES)
) i_manch_tx_properties (
	.i_clk_100m  (i_clk_100m),
	.i_rst_n     (i_rst_n),
	.i_tx_start  (i_tx_start),
	.i_tx_count  (i_tx_count),
	.i_state     (state),
	.i_cyc_cnt   (cyc_cnt),
	.i_line      (o_tx_line),
	.i_frame_done(o_tx_frame_done)
);

// ==== testbench/manch_link_tb.sv ====
// Loopback testbench for the Manchester link, runs the directed tests and prints the final verdict
`timescale 1ns/1ps

module manch_link_tb;

	localparam int BIT_CYCLES = 10;
	localparam int BUF_DEPTH = 16;
	localparam int CLK_PERIOD = 10;
	// Four frames, 13 bytes in all, doubled, plus writes and idle waits
	localparam int WATCHDOG_CYCLES =
		2 * (4 * line_pkg::PREAMBLE_CYCLES + 13 * 11 * BIT_CYCLES) + 2000;

	// Handshake lines watched by await_level
	localparam int SEL_WR_ACK = 0;
	localparam int SEL_SEND_ACK = 1;
	localparam int SEL_RX_REQ = 2;

	logic                clk_100m;
	logic                rst_n;
	logic                wr_req;
	frame_pkg::byte_t    wr_byte;
	logic                wr_ack;
	logic                send_req;
	logic                send_ack;
	logic                tx_line;
	logic                rx_req;
	frame_pkg::rx_byte_t rx_byte;
	logic                rx_ack;

	int                  seed = 32'h32ac;
	// Bytes of the frame most recently loaded
	frame_pkg::byte_t    payload[$];

	// Transmit line looped back into the receiver
	manch_link_top #(
		.BIT_CYCLES(BIT_CYCLES),
		.BUF_DEPTH (BUF_DEPTH)
	) i_manch_link_top (
		.i_clk_100m(clk_100m),
		.i_rst_n   (rst_n),
		.i_wr_req  (wr_req),
		.i_wr_byte (wr_byte),
		.o_wr_ack  (wr_ack),
		.i_send_req(send_req),
		.o_send_ack(send_ack),
		.o_tx_line (tx_line),
		.i_rx_line (tx_line),
		.o_rx_req  (rx_req),
		.o_rx_byte (rx_byte),
		.i_rx_ack  (rx_ack)
	);

	initial begin
		clk_100m = 1'b0;
		forever #(CLK_PERIOD / 2) clk_100m = ~clk_100m;
	end

	// ------------------------------
	// Reporting and waiting
	// ------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else fail_run($sformatf("error at %0t ns: %s is 0x%0h, expected 0x%0h",
			$time, name, got, exp));
	endtask

	function automatic logic handshake_level(input int sel);
		case (sel)
			SEL_WR_ACK:   return wr_ack;
			SEL_SEND_ACK: return send_ack;
			default:      return rx_req;
		endcase
	endfunction

	// Bounded wait for a handshake line, sampled on rising edges
	task automatic await_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (handshake_level(sel) != level) begin
			@(posedge clk_100m);
			n++;
			if (n > limit)
				fail_run(what);
		end
	endtask

	// Preamble plus start, eight data and stop cells per byte
	function automatic int frame_cycles(input int n);
		return line_pkg::PREAMBLE_CYCLES + n * 11 * BIT_CYCLES;
	endfunction

	// ------------------------------
	// Host side handshakes
	// ------------------------------
	task automatic write_byte(input frame_pkg::byte_t value, output logic acked);
		int n;
		@(posedge clk_100m);
		wr_byte <= value;
		wr_req  <= 1'b1;
		acked = 1'b0;
		n = 0;
		// Full buffer never answers, give up after a short wait
		while (!acked && (n < 8)) begin
			@(posedge clk_100m);
			acked = wr_ack;
			n++;
		end
		wr_req <= 1'b0;
		if (acked)
			await_level(SEL_WR_ACK, 1'b0, 8, "o_wr_ack stayed high after the request fell");
	endtask

	// Fresh random payload, every byte must be accepted
	task automatic load_frame(input int n);
		frame_pkg::byte_t b;
		logic             acked;
		payload.delete();
		repeat (n) begin
			b = frame_pkg::byte_t'($random(seed));
			payload.push_back(b);
			write_byte(b, acked);
			assert (acked)
			else fail_run("a byte write into a non-full buffer was not acknowledged");
		end
	endtask

	task automatic send_frame(input int n);
		@(posedge clk_100m);
		send_req <= 1'b1;
		await_level(SEL_SEND_ACK, 1'b1, frame_cycles(n) + 4 * BIT_CYCLES,
			"timeout: o_send_ack never rose after the send request");
		send_req <= 1'b0;
		await_level(SEL_SEND_ACK, 1'b0, 8, "o_send_ack stayed high after the request fell");
	endtask

	// Take one offered byte and compare it
	task automatic expect_byte(input frame_pkg::byte_t exp_data, input logic exp_overrun);
		frame_pkg::rx_byte_t got;
		await_level(SEL_RX_REQ, 1'b1, frame_cycles(1) + 4 * BIT_CYCLES,
			"timeout: the receiver offered no byte");
		got = rx_byte;
		rx_ack <= 1'b1;
		await_level(SEL_RX_REQ, 1'b0, 8, "o_rx_req stayed high after the acknowledge");
		rx_ack <= 1'b0;
		check_value("o_rx_byte.data", int'(got.data), int'(exp_data));
		check_value("o_rx_byte.overrun", int'(got.overrun), int'(exp_overrun));
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic test_reset();
		check_value("o_wr_ack", int'(wr_ack), 0);
		check_value("o_send_ack", int'(send_ack), 0);
		check_value("o_rx_req", int'(rx_req), 0);
		check_value("o_tx_line", int'(tx_line), 0);
	endtask

	task automatic test_single_byte();
		load_frame(1);
		fork
			send_frame(1);
			expect_byte(payload[0], 1'b0);
		join
	endtask

	task automatic test_multi_byte();
		int i;
		load_frame(8);
		fork
			send_frame(8);
			begin
				for (i = 0; i < 8; i++)
					expect_byte(payload[i], 1'b0);
			end
		join
	endtask

	task automatic test_overrun();
		frame_pkg::byte_t first;
		load_frame(3);
		first = payload[0];
		// No acknowledge while the frame runs
		send_frame(3);
		repeat (2 * BIT_CYCLES) @(posedge clk_100m);
		check_value("o_rx_req", int'(rx_req), 1);
		check_value("o_rx_byte.data", int'(rx_byte.data), int'(first));
		expect_byte(first, 1'b0);
		// Later bytes were dropped, nothing more to offer
		repeat (11 * BIT_CYCLES) begin
			@(posedge clk_100m);
			check_value("o_rx_req", int'(rx_req), 0);
		end
		load_frame(1);
		fork
			send_frame(1);
			expect_byte(payload[0], 1'b1);
		join
	endtask

	task automatic test_full_buffer();
		logic acked;
		load_frame(BUF_DEPTH);
		write_byte(frame_pkg::byte_t'($random(seed)), acked);
		assert (!acked)
		else fail_run("a write into a full buffer was acknowledged");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		rst_n    = 1'b0;
		wr_req   = 1'b0;
		wr_byte  = '0;
		send_req = 1'b0;
		rx_ack   = 1'b0;
		repeat (2) @(posedge clk_100m);
		rst_n <= 1'b1;
		@(posedge clk_100m);
		test_reset();
		test_single_byte();
		test_multi_byte();
		test_overrun();
		test_full_buffer();
		repeat (4) @(posedge clk_100m);
		if (i_manch_link_top.i_manch_tx.i_manch_tx_properties.timing_bad) begin
			fail_run("a transmitter line timing assertion failed");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_run("timeout: the tests did not finish within the expected time");
	end

endmodule

// ==== sim.f ====
logic/line_pkg.sv
logic/frame_pkg.sv
logic/tx_frame_buffer.sv
logic/manch_tx.sv
logic/manch_rx.sv
logic/manch_link_top.sv
testbench/manch_tx_properties.sv
testbench/manch_link_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vmanch_link_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

$(SIM): sim.f $(shell cat sim.f)
	verilator --binary --assert --top-module manch_link_tb -f sim.f

clean:
	rm -rf obj_dir
